// File: files.f
+incdir+hw
hw/cmprs_pkg.sv
hw/cmprs_regs.sv
hw/cmprs_tile_buf.sv
hw/cmprs_macroblock_seq.sv
hw/cmprs_block_average.sv
hw/jp_channel.sv
verif/jp_channel_tb.sv

// File: Makefile
TOP = jp_channel_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "TB PASSED"

clean:
	rm -rf obj_dir

// File: verif/jp_channel_tb.sv
// jp channel testbench
`default_nettype none

module jp_channel_tb;
    logic        xclk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        buf_wr;
    logic [63:0] buf_wdata;
    logic        buf_wpage_nxt;
    logic        xfer_reset_page_rd;
    logic        page_ready_chn;
    logic        next_page_chn;
    logic [9:0]  yc_nodc;
    logic [7:0]  yc_avr;
    logic        yc_nodc_dv;
    logic        yc_nodc_ds;
    logic [1:0]  yc_nodc_tn;
    logic        yc_nodc_first;
    logic        yc_nodc_last;
    logic [31:0] seed;        // xorshift state
    logic [63:0] pages [$];   // loaded words, page after page
    int          rel_cnt;     // next_page_chn pulses
    int          frames;      // expected frames_done

    jp_channel jp_channel_inst (.*);

    initial begin
        xclk = 1'b0;
        forever #4 xclk = ~xclk;
    end

    always @(negedge xclk) begin
        if (next_page_chn)
            rel_cnt = rel_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        @(posedge xclk);
        #1;
        psel   = 1'b1; // setup phase
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge xclk);
        #1;
        penable = 1'b1;
        #2; // mid access phase
        check("pready", 32'(pready), 1);
        check("pslverr", 32'(pslverr), 32'(exp_err));
        rdata = prdata;
        @(posedge xclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, err, unused);
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic err, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'd0, err, data);
    endtask

    // 32 words into the write page, then hand it over
    task automatic load_page();
        logic [63:0] w;
        for (int i = 0; i < 32; i++) begin
            seed      = xorshift32(seed);
            w[63:32]  = seed;
            seed      = xorshift32(seed);
            w[31:0]   = seed;
            pages.push_back(w);
            @(posedge xclk);
            #1;
            buf_wr    = 1'b1;
            buf_wdata = w;
        end
        @(posedge xclk);
        #1;
        buf_wr         = 1'b0;
        buf_wpage_nxt  = 1'b1;
        page_ready_chn = 1'b1;
        @(posedge xclk);
        #1;
        buf_wpage_nxt  = 1'b0;
        page_ready_chn = 1'b0;
    endtask

    task automatic reset_pages();
        @(posedge xclk);
        #1;
        xfer_reset_page_rd = 1'b1;
        @(posedge xclk);
        #1;
        xfer_reset_page_rd = 1'b0;
        pages.delete();
        rel_cnt = 0;
    endtask

    task automatic start_frame(input logic mono16, input logic sub_dc,
                               input logic [12:0] cols_m1, input logic [12:0] rows_m1);
        logic [2:0] mode;
        mode = mono16 ? 3'd2 : 3'd7;
        apb_write(4'h0, {27'd0, mode, sub_dc, 1'b1}, 1'b0);
        apb_write(4'h8, {3'd0, rows_m1, 3'd0, cols_m1}, 1'b0);
        apb_write(4'h4, 32'd0, 1'b0); // go
    endtask

    // pixel p of frame block blk, from page layout
    function automatic logic [7:0] model_pix(input logic mono16, input int blk, input int p);
        int mb;
        int tn;
        int word;
        mb   = mono16 ? blk / 4 : blk;
        tn   = mono16 ? blk % 4 : 0;
        word = mono16 ? ((tn / 2) * 8 + p / 8) * 2 + tn % 2 : p / 8;
        return pages[mb * 32 + word][(p % 8) * 8 +: 8];
    endfunction

    task automatic collect(input logic mono16, input logic sub_dc, input int n_blk,
                           input int frame_blks);
        int         sum;
        int         avr;
        int         wait_cnt;
        logic [9:0] exp_pix;
        @(negedge xclk);
        for (int b = 0; b < n_blk; b++) begin
            sum = 0;
            for (int p = 0; p < 64; p++)
                sum += model_pix(mono16, b, p);
            avr      = sum / 64; // floor
            wait_cnt = 0;
            while (!yc_nodc_ds) begin
                @(negedge xclk);
                wait_cnt++;
                if (wait_cnt > 4000)
                    fail_run($sformatf("timeout waiting for output block %0d", b));
            end
            check("yc_avr", 32'(yc_avr), 32'(avr));
            check("yc_nodc_tn", 32'(yc_nodc_tn), mono16 ? 32'(b % 4) : 0);
            check("yc_nodc_first", 32'(yc_nodc_first), 32'(b == 0));
            check("yc_nodc_last", 32'(yc_nodc_last), 32'(b == frame_blks - 1));
            for (int p = 0; p < 64; p++) begin
                exp_pix = sub_dc ? 10'(model_pix(mono16, b, p) - avr)
                                 : 10'(model_pix(mono16, b, p));
                check("yc_nodc_dv", 32'(yc_nodc_dv), 1);
                check("yc_nodc_ds", 32'(yc_nodc_ds), 32'(p == 0));
                check("yc_nodc", 32'(yc_nodc), 32'(exp_pix));
                @(negedge xclk);
            end
            check("yc_nodc_dv after 64", 32'(yc_nodc_dv & ~yc_nodc_ds), 0); // next ds or idle
        end
    endtask

    task automatic wait_idle(input int exp_frames);
        logic [31:0] st;
        int          tries;
        tries = 0;
        st    = 32'h1;
        while (st[0]) begin
            apb_read(4'hC, 1'b0, st);
            tries++;
            if (tries > 200)
                fail_run("timeout waiting for busy to drop");
        end
        check("frames_done", 32'(st[15:8]), 32'(exp_frames));
    endtask

    // refill each page as soon as it is released
    task automatic feed_pages(input int total);
        int wait_cnt;
        for (int n = 4; n < total; n++) begin
            wait_cnt = 0;
            while (rel_cnt < n - 3) begin
                @(posedge xclk);
                wait_cnt++;
                if (wait_cnt > 4000)
                    fail_run("timeout waiting for next_page_chn");
            end
            load_page();
        end
    endtask

    task automatic register_access();
        logic [31:0] rd;
        apb_read(4'hC, 1'b0, rd);
        check("STATUS", rd, 32'd0);
        apb_write(4'h0, 32'h1e, 1'b0); // mono8, dc on, frame off
        apb_read(4'h0, 1'b0, rd);
        check("CTRL", rd, 32'h1e);
        apb_write(4'h8, 32'h0005_0003, 1'b0);
        apb_read(4'h8, 1'b0, rd);
        check("GEOM", rd, 32'h0005_0003);
        apb_write(4'h2, 32'h1, 1'b1);  // unmapped
        apb_read(4'h6, 1'b1, rd);
        apb_write(4'hC, 32'h1, 1'b1);  // status is read only
        apb_write(4'h0, 32'h0e, 1'b1); // mode 3 unsupported
        apb_read(4'h0, 1'b0, rd);
        check("CTRL kept", rd, 32'h1e);
    endtask

    task automatic mono16_frame();
        logic [31:0] st;
        reset_pages();
        repeat (4) load_page();
        start_frame(1'b1, 1'b1, 13'd1, 13'd1);
        fork
            collect(1'b1, 1'b1, 16, 16);
            begin
                apb_read(4'hC, 1'b0, st);
                check("busy", 32'(st[0]), 1);
            end
        join
        frames++;
        wait_idle(frames);
        check("next_page_chn count", 32'(rel_cnt), 4);
    endtask

    task automatic mono8_raw_frame();
        reset_pages();
        repeat (3) load_page();
        start_frame(1'b0, 1'b0, 13'd2, 13'd0);
        collect(1'b0, 1'b0, 3, 3);
        frames++;
        wait_idle(frames);
    endtask

    task automatic page_flow();
        reset_pages();
        repeat (4) load_page();
        start_frame(1'b1, 1'b1, 13'd3, 13'd1); // 4x2 macroblocks
        fork
            collect(1'b1, 1'b1, 32, 32);
            feed_pages(8);
        join
        check("next_page_chn count", 32'(rel_cnt), 8);
        frames++;
        wait_idle(frames);
    endtask

    task automatic frame_control();
        logic [31:0] st;
        reset_pages();
        repeat (4) load_page();
        start_frame(1'b1, 1'b1, 13'd1, 13'd1);
        collect(1'b1, 1'b1, 2, 16);
        apb_write(4'h0, {27'd0, 3'd2, 1'b1, 1'b0}, 1'b0); // frame_en off
        @(posedge xclk);
        repeat (100) begin
            @(negedge xclk);
            check("yc_nodc_dv after abort", 32'(yc_nodc_dv), 0);
        end
        apb_read(4'hC, 1'b0, st);
        check("busy after abort", 32'(st[0]), 0);
        check("frames_done after abort", 32'(st[15:8]), 32'(frames));
        reset_pages();
        repeat (2) load_page();
        start_frame(1'b0, 1'b1, 13'd1, 13'd0);
        collect(1'b0, 1'b1, 2, 2);
        frames++;
        wait_idle(frames);
    endtask

    initial begin
        rst_n              = 1'b0;
        psel               = 1'b0;
        penable            = 1'b0;
        pwrite             = 1'b0;
        paddr              = 4'h0;
        pwdata             = 32'd0;
        buf_wr             = 1'b0;
        buf_wdata          = 64'd0;
        buf_wpage_nxt      = 1'b0;
        xfer_reset_page_rd = 1'b0;
        page_ready_chn     = 1'b0;
        seed               = 32'h5bdcb0e7;
        rel_cnt            = 0;
        frames             = 0;
        repeat (8) @(posedge xclk);
        #1;
        rst_n = 1'b1;
        register_access();
        mono16_frame();
        mono8_raw_frame();
        page_flow();
        frame_control();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/jp_channel.sv
// compressor channel front end
`default_nettype none
`include "cmprs_params.svh"

module jp_channel
    import cmprs_pkg::*;
(
    input  wire         xclk,               // compressor clock
    input  wire         rst_n,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  wire         buf_wr,
    input  wire  [63:0] buf_wdata,
    input  wire         buf_wpage_nxt,
    input  wire         xfer_reset_page_rd,
    input  wire         page_ready_chn,     // page filled by writer
    output logic        next_page_chn,      // page free for writer
    output logic [9:0]  yc_nodc,            // signed when dc removed
    output logic [`CMPRS_PIX_W-1:0] yc_avr, // block dc
    output logic        yc_nodc_dv,
    output logic        yc_nodc_ds,
    output logic [1:0]  yc_nodc_tn,
    output logic        yc_nodc_first,
    output logic        yc_nodc_last
);
    logic        frame_en;
    logic        subtract_dc;
    logic        frame_go;
    logic        frame_done;
    cmprs_mode_t converter_type;
    geom_t       n_blocks_in_row_m1;
    geom_t       n_block_rows_m1;
    logic        rd_req;
    logic        rd_gnt;
    buf_addr_t   rd_addr;
    logic [63:0] rd_data;
    logic        rd_valid;
    logic        blk_free;           // back-pressure to sequencer
    logic [1:0]  blk_tn;
    logic        blk_first;
    logic        blk_last;

    cmprs_regs cmprs_regs_inst (
        .xclk               (xclk),
        .rst_n              (rst_n),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pready             (pready),
        .pslverr            (pslverr),
        .frame_done         (frame_done),
        .frame_en           (frame_en),
        .subtract_dc        (subtract_dc),
        .frame_go           (frame_go),
        .converter_type     (converter_type),
        .n_blocks_in_row_m1 (n_blocks_in_row_m1),
        .n_block_rows_m1    (n_block_rows_m1),
        .busy               ()                    // seen through STATUS only
    );

    cmprs_tile_buf cmprs_tile_buf_inst (
        .xclk               (xclk),
        .rst_n              (rst_n),
        .buf_wr             (buf_wr),
        .buf_wdata          (buf_wdata),
        .buf_wpage_nxt      (buf_wpage_nxt),
        .xfer_reset_page_rd (xfer_reset_page_rd),
        .rd_req             (rd_req),
        .rd_addr            (rd_addr),
        .rd_gnt             (rd_gnt),
        .rd_data            (rd_data),
        .rd_valid           (rd_valid)
    );

    cmprs_macroblock_seq cmprs_macroblock_seq_inst (
        .xclk               (xclk),
        .rst_n              (rst_n),
        .frame_en           (frame_en),
        .frame_go           (frame_go),
        .converter_type     (converter_type),
        .n_blocks_in_row_m1 (n_blocks_in_row_m1),
        .n_block_rows_m1    (n_block_rows_m1),
        .page_ready_chn     (page_ready_chn),
        .xfer_reset_page_rd (xfer_reset_page_rd),
        .rd_gnt             (rd_gnt),
        .blk_free           (blk_free),
        .rd_req             (rd_req),
        .rd_addr            (rd_addr),
        .next_page_chn      (next_page_chn),
        .blk_tn             (blk_tn),
        .blk_first          (blk_first),
        .blk_last           (blk_last)
    );

    cmprs_block_average cmprs_block_average_inst (
        .xclk               (xclk),
        .rst_n              (rst_n),
        .frame_en           (frame_en),
        .subtract_dc        (subtract_dc),
        .rd_valid           (rd_valid),
        .rd_data            (rd_data),
        .blk_tn             (blk_tn),
        .blk_first          (blk_first),
        .blk_last           (blk_last),
        .blk_free           (blk_free),
        .frame_done         (frame_done),
        .yc_nodc            (yc_nodc),
        .yc_avr             (yc_avr),
        .yc_nodc_dv         (yc_nodc_dv),
        .yc_nodc_ds         (yc_nodc_ds),
        .yc_nodc_tn         (yc_nodc_tn),
        .yc_nodc_first      (yc_nodc_first),
        .yc_nodc_last       (yc_nodc_last)
    );

endmodule

`default_nettype wire

// File: hw/cmprs_block_average.sv
// block averager and pixel output
`default_nettype none
`include "cmprs_params.svh"

module cmprs_block_average
    import cmprs_pkg::*;
(
    input  wire         xclk,
    input  wire         rst_n,
    input  wire         frame_en,
    input  wire         subtract_dc,
    input  wire         rd_valid,      // row word from tile buffer
    input  wire  [63:0] rd_data,
    input  wire  [1:0]  blk_tn,
    input  wire         blk_first,
    input  wire         blk_last,
    output logic        blk_free,      // a half is empty
    output logic        frame_done,
    output logic [9:0]  yc_nodc,
    output logic [`CMPRS_PIX_W-1:0] yc_avr,
    output logic        yc_nodc_dv,    // 64 cycles per block
    output logic        yc_nodc_ds,    // first pixel of block
    output logic [1:0]  yc_nodc_tn,
    output logic        yc_nodc_first,
    output logic        yc_nodc_last
);
    localparam int PW = `CMPRS_PIX_W;
    localparam int RW = $clog2(`CMPRS_BLK_ROWS);
    localparam int SW = PW + 2 * RW; // sum of 64 pixels

    logic [63:0]     store [0:2*`CMPRS_BLK_ROWS-1]; // {half, row}
    logic [PW-1:0]   half_avr [0:1];
    logic [1:0]      half_tn [0:1];
    logic [1:0]      half_first;
    logic [1:0]      half_last;
    logic [1:0]      full;       // half holds a complete block
    logic            whalf;      // half being filled
    logic            rhalf;      // half drained or next to drain
    logic [RW-1:0]   wcnt;       // row words in whalf
    logic            draining;
    logic [2*RW-1:0] pcnt;       // pixel in block
    logic [SW-1:0]   sum;
    logic [SW-1:0]   word_sum;
    logic [SW-1:0]   blk_sum;
    logic            fill;
    logic            fill_done;  // eighth row word this cycle
    logic            last_pix;
    logic            nxt;        // half to drain after this cycle
    logic            next_full;
    logic [63:0]     rword;
    logic [PW-1:0]   pix;

    always_comb begin
        word_sum = '0;
        for (int i = 0; i < 64 / PW; i++)
            word_sum = word_sum + SW'(rd_data[i*PW +: PW]);
    end

    assign blk_sum   = (wcnt == '0 ? '0 : sum) + word_sum;
    assign fill      = rd_valid & frame_en; // stray words dropped after abort
    assign fill_done = fill && wcnt == '1;
    assign last_pix  = draining && pcnt == '1;
    assign nxt       = draining ? ~rhalf : rhalf;
    assign next_full = full[nxt] || (fill_done && whalf == nxt); // back to back
    assign blk_free  = !(full[0] || (!whalf && wcnt != '0)) ||
                       !(full[1] || (whalf && wcnt != '0));

    // block store, sum and per-half flags
    always_ff @(posedge xclk) begin
        if (fill) begin
            store[{whalf, wcnt}] <= rd_data;
            sum                  <= blk_sum;
            if (wcnt == '0) begin
                half_tn[whalf]    <= blk_tn;
                half_first[whalf] <= blk_first;
                half_last[whalf]  <= blk_last;
            end
            if (fill_done)
                half_avr[whalf] <= blk_sum[SW-1 -: PW]; // floor of sum / 64
        end
    end

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n || !frame_en) begin
            wcnt       <= '0;
            whalf      <= 1'b0;
            rhalf      <= 1'b0;
            full       <= 2'b00;
            draining   <= 1'b0;
            pcnt       <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_pix && half_last[rhalf];
            if (fill) begin
                wcnt <= wcnt + 1'b1;
                if (fill_done)
                    whalf <= ~whalf;
            end
            if (fill_done)
                full[whalf] <= 1'b1;
            if (last_pix) begin
                full[rhalf] <= 1'b0;
                rhalf       <= ~rhalf;
                draining    <= next_full;
            end else if (!draining) begin
                draining <= next_full; // starts cycle after eighth word
            end
            if (draining)
                pcnt <= pcnt + 1'b1; // wraps to 0 at block end
        end
    end

    assign rword         = store[{rhalf, pcnt[2*RW-1 -: RW]}];
    assign pix           = rword[pcnt[RW-1:0]*PW +: PW]; // byte 0 leftmost
    assign yc_avr        = half_avr[rhalf];
    assign yc_nodc       = subtract_dc ? {2'b00, pix} - {2'b00, yc_avr} : {2'b00, pix};
    assign yc_nodc_dv    = draining;
    assign yc_nodc_ds    = draining && pcnt == '0;
    assign yc_nodc_tn    = half_tn[rhalf];
    assign yc_nodc_first = half_first[rhalf];
    assign yc_nodc_last  = half_last[rhalf];

    // sequencer must hold off while both halves are taken
    a_no_overrun: assert property (@(posedge xclk) disable iff (!rst_n)
        rd_valid |-> !(full[0] && full[1]));

endmodule

`default_nettype wire

// File: hw/cmprs_macroblock_seq.sv
// macroblock sequencer
`default_nettype none
`include "cmprs_params.svh"

module cmprs_macroblock_seq
    import cmprs_pkg::*;
(
    input  wire         xclk,
    input  wire         rst_n,
    input  wire         frame_en,
    input  wire         frame_go,
    input  wire         cmprs_mode_t converter_type,
    input  wire         geom_t n_blocks_in_row_m1,
    input  wire         geom_t n_block_rows_m1,
    input  wire         page_ready_chn,     // writer filled a page
    input  wire         xfer_reset_page_rd,
    input  wire         rd_gnt,
    input  wire         blk_free,           // averager has an empty half
    output logic        rd_req,
    output buf_addr_t   rd_addr,
    output logic        next_page_chn,      // page released to writer
    output logic [1:0]  blk_tn,
    output logic        blk_first,
    output logic        blk_last
);
    localparam int PW = $clog2(`CMPRS_PAGES);
    localparam int AW = PW + 1;
    localparam int RW = $clog2(`CMPRS_BLK_ROWS);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_WAIT = 2'd1; // page and free half needed
    localparam logic [1:0] S_READ = 2'd2; // eight row reads

    logic [1:0]    state;
    logic [AW-1:0] avail;     // filled pages not yet released
    logic [PW-1:0] rpage;     // page being read
    logic [RW-1:0] row;
    geom_t         mb_x;
    geom_t         mb_y;
    logic          mono8;
    logic          last_tn;   // block is the last one of the page
    logic          mb_last_x;
    logic          mb_last_y;
    logic          row_done;  // last row of block granted
    logic          page_done; // last row of page granted

    assign mono8     = converter_type == CMPRS_MONO8;
    assign last_tn   = mono8 || blk_tn == 2'd3;
    assign mb_last_x = mb_x == n_blocks_in_row_m1;
    assign mb_last_y = mb_y == n_block_rows_m1;
    assign row_done  = rd_gnt && row == RW'(`CMPRS_BLK_ROWS - 1);
    assign page_done = row_done && last_tn;

    assign rd_req    = state == S_READ;
    // mono16 word = {by, row, bx}, mono8 word = row
    assign rd_addr   = mono8 ? {rpage, 2'b00, row} : {rpage, blk_tn[1], row, blk_tn[0]};
    assign blk_first = mb_x == '0 && mb_y == '0 && blk_tn == 2'd0;
    assign blk_last  = mb_last_x && mb_last_y && last_tn;

    // page accounting, survives frame_en
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            avail         <= '0;
            rpage         <= '0;
            next_page_chn <= 1'b0;
        end else begin
            next_page_chn <= page_done;
            if (xfer_reset_page_rd) begin
                avail <= '0;
                rpage <= '0;
            end else begin
                avail <= avail + AW'(page_ready_chn) - AW'(page_done);
                if (page_done)
                    rpage <= rpage + 1'b1;
            end
        end
    end

    // block and macroblock walk
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n || !frame_en) begin
            state  <= S_IDLE;
            row    <= '0;
            blk_tn <= 2'd0;
            mb_x   <= '0;
            mb_y   <= '0;
        end else begin
            case (state)
                S_IDLE: if (frame_go) state <= S_WAIT;
                S_WAIT: if (avail != '0 && blk_free) state <= S_READ;
                S_READ: if (rd_gnt) begin
                    row <= row + 1'b1; // wraps to 0 after row 7
                    if (row_done) begin
                        state  <= S_WAIT;
                        blk_tn <= blk_tn + 2'd1;
                    end
                    if (page_done) begin
                        blk_tn <= 2'd0;
                        if (mb_last_x) begin
                            mb_x <= '0;
                            mb_y <= mb_y + 1'b1;
                            if (mb_last_y) begin
                                state <= S_IDLE; // frame fully read
                                mb_y  <= '0;
                            end
                        end else begin
                            mb_x <= mb_x + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // writer must wait for a released page
    a_no_overfill: assert property (@(posedge xclk) disable iff (!rst_n)
        page_ready_chn |-> avail != AW'(`CMPRS_PAGES));

endmodule

`default_nettype wire

// File: hw/cmprs_tile_buf.sv
// four-page tile buffer
`default_nettype none
`include "cmprs_params.svh"

module cmprs_tile_buf
    import cmprs_pkg::*;
(
    input  wire         xclk,
    input  wire         rst_n,
    input  wire         buf_wr,             // next word of write page
    input  wire  [63:0] buf_wdata,
    input  wire         buf_wpage_nxt,      // advance write page
    input  wire         xfer_reset_page_rd, // back to page 0, word 0
    input  wire         rd_req,             // held until granted
    input  wire         buf_addr_t rd_addr,
    output logic        rd_gnt,
    output logic [63:0] rd_data,
    output logic        rd_valid            // one cycle after rd_gnt
);
    localparam int PW    = $clog2(`CMPRS_PAGES);
    localparam int WW    = $clog2(`CMPRS_PAGE_WORDS);
    localparam int DEPTH = `CMPRS_PAGES * `CMPRS_PAGE_WORDS;

    logic [63:0]   mem [0:DEPTH-1]; // single port, 128 x 64
    logic [PW-1:0] wpage;           // page being filled
    logic [WW-1:0] wword;           // word within it

    assign rd_gnt = rd_req & ~buf_wr; // writer has priority

    // write pointer
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            wpage <= '0;
            wword <= '0;
        end else if (xfer_reset_page_rd) begin
            wpage <= '0;
            wword <= '0;
        end else if (buf_wpage_nxt) begin
            wpage <= wpage + 1'b1; // wraps mod 4
            wword <= '0;
        end else if (buf_wr) begin
            wword <= wword + 1'b1;
        end
    end

    // one port, either write or read per cycle
    always_ff @(posedge xclk) begin
        if (buf_wr)
            mem[{wpage, wword}] <= buf_wdata;
        else if (rd_gnt)
            rd_data <= mem[rd_addr];
    end

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_gnt;
    end

    // a waiting read keeps its address until granted
    a_addr_held: assert property (@(posedge xclk) disable iff (!rst_n)
        rd_req && !rd_gnt |=> !rd_req || $stable(rd_addr));

endmodule

`default_nettype wire

// File: hw/cmprs_regs.sv
// APB control registers
`default_nettype none
`include "cmprs_params.svh"

module cmprs_regs
    import cmprs_pkg::*;
(
    input  wire         xclk,
    input  wire         rst_n,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [3:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  wire         frame_done,         // last pixel of frame left
    output logic        frame_en,           // low clears sequencer and averager
    output logic        subtract_dc,
    output logic        frame_go,           // one-cycle start pulse
    output cmprs_mode_t converter_type,
    output geom_t       n_blocks_in_row_m1,
    output geom_t       n_block_rows_m1,
    output logic        busy
);
    logic       access;      // apb access phase
    logic       wr_ok;       // write accepted
    logic       type_ok;     // supported converter code on pwdata
    logic       go_ok;       // GO accepted, frame starts
    logic [7:0] frames_done; // wraps at 256

    assign access  = psel & penable;
    assign pready  = 1'b1; // zero wait states
    assign type_ok = (pwdata[4:2] == CMPRS_MONO16) || (pwdata[4:2] == CMPRS_MONO8);
    assign wr_ok   = access & pwrite & ~pslverr;
    assign go_ok   = wr_ok && (paddr == 4'h4) && frame_en && !busy;

    // read mux and error decode
    always_comb begin
        pslverr = 1'b0;
        prdata  = '0;
        case (paddr)
            4'h0: begin
                prdata  = {27'd0, converter_type, subtract_dc, frame_en};
                pslverr = access & pwrite & ~type_ok; // CTRL kept on bad mode
            end
            4'h4: prdata = '0; // GO reads as zero
            4'h8: prdata = {3'd0, n_block_rows_m1, 3'd0, n_blocks_in_row_m1};
            4'hC: begin
                prdata  = {16'd0, frames_done, 7'd0, busy};
                pslverr = access & pwrite; // status is read only
            end
            default: pslverr = access;
        endcase
    end

    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            frame_en           <= 1'b0;
            subtract_dc        <= 1'b0;
            converter_type     <= CMPRS_MONO16;
            n_blocks_in_row_m1 <= '0;
            n_block_rows_m1    <= '0;
            frame_go           <= 1'b0;
            busy               <= 1'b0;
            frames_done        <= '0;
        end else begin
            frame_go <= go_ok;
            if (wr_ok && paddr == 4'h0) begin
                frame_en       <= pwdata[0];
                subtract_dc    <= pwdata[1];
                converter_type <= cmprs_mode_t'(pwdata[4:2]);
            end
            if (wr_ok && paddr == 4'h8) begin
                n_blocks_in_row_m1 <= pwdata[12:0];
                n_block_rows_m1    <= pwdata[28:16];
            end
            if (!frame_en || frame_done)
                busy <= 1'b0; // aborted or drained
            else if (go_ok)
                busy <= 1'b1;
            if (frame_done)
                frames_done <= frames_done + 8'd1;
        end
    end

    // setup phase always followed by its access phase
    a_apb_setup: assert property (@(posedge xclk) disable iff (!rst_n)
        psel && !penable |=> psel && penable && $stable(paddr));

endmodule

`default_nettype wire

// File: hw/cmprs_pkg.sv
// compressor channel types
`default_nettype none
`include "cmprs_params.svh"

package cmprs_pkg;

    // converter modes, codes kept from the full channel
    typedef enum logic [2:0] {
        CMPRS_MONO16 = 3'd2, // 16x16 macroblock, four blocks
        CMPRS_MONO8  = 3'd7  // 8x8 macroblock, one block
    } cmprs_mode_t;

    typedef logic [`CMPRS_BUF_AW-1:0] buf_addr_t; // page in msbs, word in lsbs
    typedef logic [`CMPRS_GEOM_W-1:0] geom_t;     // block count minus one

endpackage

`default_nettype wire

// File: hw/cmprs_params.svh
// compressor channel sizes
`ifndef CMPRS_PARAMS_SVH
`define CMPRS_PARAMS_SVH

// tile buffer
`define CMPRS_PAGES       4   // pages in the tile buffer
`define CMPRS_PAGE_WORDS  32  // 64-bit words per page
`define CMPRS_BUF_AW      7   // {page, word} address

// frame geometry
`define CMPRS_GEOM_W      13  // block count register width

// block shape
`define CMPRS_BLK_ROWS    8   // row words per 8x8 block
`define CMPRS_PIX_W       8   // bits per pixel

`endif
